/* Makefile */
TOP := tlp_gen_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tlp_gen.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

/* include/tlp_macros.svh */
`ifndef TLP_MACROS_SVH
`define TLP_MACROS_SVH

// APB register map, byte addresses
`define TLP_ADDR_CTRL  8'h00     // Kind, fmt and attribute controls
`define TLP_ADDR_LEN   8'h04     // Length and byte enables
`define TLP_ADDR_ID    8'h08     // Bus, device, function numbers
`define TLP_ADDR_TAG   8'h0C     // Tag and completion fields
`define TLP_ADDR_CPL   8'h10     // Completer ID, lower address, register
`define TLP_ADDR_ALO   8'h14     // Address bits 31:0
`define TLP_ADDR_AHI   8'h18     // Address bits 63:32
`define TLP_ADDR_DW0   8'h20     // Header words, read only
`define TLP_ADDR_DW1   8'h24
`define TLP_ADDR_DW2   8'h28
`define TLP_ADDR_DW3   8'h2C
`define TLP_ADDR_STAT  8'h30     // Tag error and 4DW flag

// Header kinds selected by CTRL
`define TLP_KIND_W     3
`define TLP_KIND_MEM   3'd0
`define TLP_KIND_IO    3'd1
`define TLP_KIND_CFG0  3'd2
`define TLP_KIND_CPL   3'd3

// DW0 type field
`define TLP_TYPE_MEM   5'b00000
`define TLP_TYPE_IO    5'b00010
`define TLP_TYPE_CFG0  5'b00100
`define TLP_TYPE_CPL   5'b01010

// Fmt bit positions
`define TLP_FMT_DATA_BIT 1       // Payload follows header
`define TLP_FMT_4DW_BIT  0       // Four DW header

// Field widths
`define TLP_LEN_W      10
`define TLP_TAG_W      10
`define TLP_ID_W       16
`define TLP_DW_W       32
`define TLP_APB_AW     8

`define TLP_SUPPORT_10BIT_TAG_DEF 0 // 8-bit tags by default

`endif

/* logic/tlp_apb_regs.sv */
`timescale 1ns/1ps
`include "tlp_macros.svh"

module tlp_apb_regs
    import tlp_pkg::*;
(
    input  logic                   pclk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`TLP_APB_AW-1:0] paddr,
    input  logic [`TLP_DW_W-1:0]   pwdata,
    output logic [`TLP_DW_W-1:0]   prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic [`TLP_KIND_W-1:0] kind,
    output logic                   has_data,
    output logic                   addr64,
    output logic                   td,
    output logic                   ep,
    output logic [2:0]             tc,
    output logic [2:0]             attr,
    output logic                   ari_enabled,
    output logic [3:0]             ext_reg,
    output logic [`TLP_LEN_W-1:0]  length,
    output logic [3:0]             first_be,
    output logic [3:0]             last_be,
    output logic [7:0]             bus,
    output logic [4:0]             dev,
    output logic [2:0]             fn,
    output logic [7:0]             ari_fn,
    output logic [`TLP_TAG_W-1:0]  tag,
    output logic [2:0]             cpl_status,
    output logic                   bcm,
    output logic [11:0]            byte_count,
    output logic [`TLP_ID_W-1:0]   completer_id,
    output logic [6:0]             lower_addr,
    output logic [5:0]             reg_num,
    output logic [`TLP_DW_W-1:0]   addr_lo,
    output logic [`TLP_DW_W-1:0]   addr_hi,
    input  logic [`TLP_DW_W-1:0]   hdr_dw0,
    input  tlp_dw1_u               hdr_dw1,
    input  logic [`TLP_DW_W-1:0]   hdr_dw2,
    input  logic [`TLP_DW_W-1:0]   hdr_dw3,
    input  logic                   four_dw_q,
    input  logic                   tag_error_q
);

    logic [17:0] ctrl_q;                 // Only defined field bits stored
    logic [17:0] len_q;
    logic [23:0] id_q;
    logic [25:0] tag_q;
    logic [28:0] cpl_q;
    logic [31:0] alo_q;
    logic [31:0] ahi_q;
    logic        addr_rw;                // Field register hit
    logic        addr_ro;                // Header or status hit
    logic        access;                 // APB access phase
    logic        wr_en;

    assign access  = psel && penable;
    assign addr_rw = (paddr == `TLP_ADDR_CTRL) || (paddr == `TLP_ADDR_LEN) ||
                     (paddr == `TLP_ADDR_ID)   || (paddr == `TLP_ADDR_TAG) ||
                     (paddr == `TLP_ADDR_CPL)  || (paddr == `TLP_ADDR_ALO) ||
                     (paddr == `TLP_ADDR_AHI);
    assign addr_ro = (paddr == `TLP_ADDR_DW0) || (paddr == `TLP_ADDR_DW1) ||
                     (paddr == `TLP_ADDR_DW2) || (paddr == `TLP_ADDR_DW3) ||
                     (paddr == `TLP_ADDR_STAT);
    assign wr_en   = access && pwrite && addr_rw; // RO and unmapped writes dropped
    assign pready  = 1'b1;                        // Zero wait states
    assign pslverr = access && (!(addr_rw || addr_ro) || (pwrite && addr_ro));

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
            len_q  <= '0;
            id_q   <= '0;
            tag_q  <= '0;
            cpl_q  <= '0;
            alo_q  <= '0;
            ahi_q  <= '0;
        end else if (wr_en) begin
            case (paddr)
                `TLP_ADDR_CTRL: ctrl_q <= pwdata[17:0];
                `TLP_ADDR_LEN:  len_q  <= pwdata[17:0];
                `TLP_ADDR_ID:   id_q   <= pwdata[23:0];
                `TLP_ADDR_TAG:  tag_q  <= pwdata[25:0];
                `TLP_ADDR_CPL:  cpl_q  <= pwdata[28:0];
                `TLP_ADDR_ALO:  alo_q  <= pwdata;
                `TLP_ADDR_AHI:  ahi_q  <= pwdata;
                default: ;
            endcase
        end
    end

    // Read mux, valid in the access cycle
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                `TLP_ADDR_CTRL: prdata = {14'd0, ctrl_q};
                `TLP_ADDR_LEN:  prdata = {14'd0, len_q};
                `TLP_ADDR_ID:   prdata = {8'd0, id_q};
                `TLP_ADDR_TAG:  prdata = {6'd0, tag_q};
                `TLP_ADDR_CPL:  prdata = {3'd0, cpl_q};
                `TLP_ADDR_ALO:  prdata = alo_q;
                `TLP_ADDR_AHI:  prdata = ahi_q;
                `TLP_ADDR_DW0:  prdata = hdr_dw0;
                `TLP_ADDR_DW1:  prdata = hdr_dw1;
                `TLP_ADDR_DW2:  prdata = hdr_dw2;
                `TLP_ADDR_DW3:  prdata = hdr_dw3;
                `TLP_ADDR_STAT: prdata = {30'd0, four_dw_q, tag_error_q};
                default: ;
            endcase
        end
    end

    assign kind         = ctrl_q[2:0];
    assign has_data     = ctrl_q[3];
    assign addr64       = ctrl_q[4];
    assign td           = ctrl_q[5];
    assign ep           = ctrl_q[6];
    assign tc           = ctrl_q[9:7];
    assign attr         = ctrl_q[12:10];
    assign ari_enabled  = ctrl_q[13];
    assign ext_reg      = ctrl_q[17:14];
    assign length       = len_q[9:0];
    assign first_be     = len_q[13:10];
    assign last_be      = len_q[17:14];
    assign bus          = id_q[7:0];
    assign dev          = id_q[12:8];
    assign fn           = id_q[15:13];
    assign ari_fn       = id_q[23:16];
    assign tag          = tag_q[9:0];
    assign cpl_status   = tag_q[12:10];
    assign bcm          = tag_q[13];
    assign byte_count   = tag_q[25:14];
    assign completer_id = cpl_q[15:0];
    assign lower_addr   = cpl_q[22:16];
    assign reg_num      = cpl_q[28:23];
    assign addr_lo      = alo_q;
    assign addr_hi      = ahi_q;

    // Error response only in a real access phase, after a setup phase
    a_slverr_access: assert property (@(posedge pclk) disable iff (!rst_n)
        pslverr |-> penable && $past(psel && !penable));

endmodule

/* logic/tlp_dw0_encode.sv */
`timescale 1ns/1ps
`include "tlp_macros.svh"

module tlp_dw0_encode
    import tlp_pkg::*;
(
    input  logic [`TLP_KIND_W-1:0] kind,
    input  logic                   has_data,
    input  logic                   addr64,
    input  logic                   td,
    input  logic                   ep,
    input  logic [2:0]             tc,
    input  logic [2:0]             attr,
    input  logic [`TLP_LEN_W-1:0]  length,
    output logic [`TLP_DW_W-1:0]   dw0_base,
    output logic                   four_dw
);

    logic [2:0]            fmt;
    logic [4:0]            type_code;
    logic [2:0]            tc_eff;
    logic [2:0]            attr_eff;
    logic                  td_eff;
    logic                  ep_eff;
    logic [`TLP_LEN_W-1:0] len_eff;

    assign four_dw = (kind == `TLP_KIND_MEM) && addr64;  // Only memory gets 64-bit addr

    always_comb begin
        fmt                    = 3'b000;
        fmt[`TLP_FMT_DATA_BIT] = has_data;
        fmt[`TLP_FMT_4DW_BIT]  = four_dw;
    end

    always_comb begin
        type_code = `TLP_TYPE_MEM;       // Unknown kinds fall back to MEM
        tc_eff    = tc;
        attr_eff  = attr;
        td_eff    = td;
        ep_eff    = ep;
        len_eff   = length;
        case (kind)
            `TLP_KIND_IO: begin
                type_code = `TLP_TYPE_IO;
                tc_eff    = 3'd0;        // IO is TC0, no ordering attrs
                attr_eff  = 3'd0;
                len_eff   = 10'd1;       // Always one DW
            end
            `TLP_KIND_CFG0: begin
                type_code = `TLP_TYPE_CFG0;
                tc_eff    = 3'd0;
                attr_eff  = 3'd0;
                len_eff   = 10'd1;
                td_eff    = 1'b0;
                ep_eff    = 1'b0;
            end
            `TLP_KIND_CPL: begin
                type_code = `TLP_TYPE_CPL;
                td_eff    = 1'b0;
                ep_eff    = 1'b0;
            end
            default: ;
        endcase
    end

    // T9 and T8 slots left zero, filled downstream
    assign dw0_base = {fmt, type_code, 1'b0, tc_eff, 1'b0, attr_eff[2], 2'b00,
                       td_eff, ep_eff, attr_eff[1:0], 2'b00, len_eff};

endmodule

/* logic/tlp_gen_top.sv */
`timescale 1ns/1ps
`include "tlp_macros.svh"

module tlp_gen_top
    import tlp_pkg::*;
#(
    parameter int support_10bit_tag = `TLP_SUPPORT_10BIT_TAG_DEF
)
(
    input  logic                   pclk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`TLP_APB_AW-1:0] paddr,
    input  logic [`TLP_DW_W-1:0]   pwdata,
    output logic [`TLP_DW_W-1:0]   prdata,
    output logic                   pready,
    output logic                   pslverr
);

    logic [`TLP_KIND_W-1:0] kind;
    logic                   has_data, addr64, td, ep, ari_enabled, bcm;
    logic [2:0]             tc, attr, fn, cpl_status;
    logic [3:0]             ext_reg, first_be, last_be;
    logic [`TLP_LEN_W-1:0]  length;
    logic [7:0]             bus, ari_fn;
    logic [4:0]             dev;
    logic [`TLP_TAG_W-1:0]  tag, tag_hdr;
    logic [11:0]            byte_count;
    logic [`TLP_ID_W-1:0]   completer_id, requester_id;
    logic [6:0]             lower_addr;
    logic [5:0]             reg_num;
    logic [`TLP_DW_W-1:0]   addr_lo, addr_hi, dw0_base;
    logic [`TLP_DW_W-1:0]   hdr_dw0, hdr_dw2, hdr_dw3;
    tlp_dw1_u               hdr_dw1;     // Request or completion view
    logic                   tag_error, four_dw, four_dw_q, tag_error_q;

    tlp_apb_regs u_regs (
        .pclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .kind, .has_data, .addr64, .td, .ep, .tc, .attr, .ari_enabled, .ext_reg,
        .length, .first_be, .last_be, .bus, .dev, .fn, .ari_fn,
        .tag, .cpl_status, .bcm, .byte_count, .completer_id, .lower_addr, .reg_num,
        .addr_lo, .addr_hi,
        .hdr_dw0, .hdr_dw1, .hdr_dw2, .hdr_dw3, .four_dw_q, .tag_error_q
    );

    tlp_req_id_tag #(.support_10bit_tag(support_10bit_tag)) u_id_tag (
        .bus, .dev, .fn, .ari_fn, .ari_enabled, .tag,
        .requester_id, .tag_hdr, .tag_error
    );

    tlp_dw0_encode u_dw0 (
        .kind, .has_data, .addr64, .td, .ep, .tc, .attr, .length,
        .dw0_base, .four_dw
    );

    tlp_hdr_assemble u_hdr (
        .pclk, .rst_n, .kind, .dw0_base, .four_dw, .requester_id, .tag_hdr, .tag_error,
        .first_be, .last_be, .completer_id, .cpl_status, .bcm, .byte_count, .lower_addr,
        .addr_lo, .addr_hi, .bus, .dev, .fn, .reg_num, .ext_reg,
        .hdr_dw0, .hdr_dw1, .hdr_dw2, .hdr_dw3, .four_dw_q, .tag_error_q
    );

endmodule

/* logic/tlp_hdr_assemble.sv */
`timescale 1ns/1ps
`include "tlp_macros.svh"

module tlp_hdr_assemble
    import tlp_pkg::*;
(
    input  logic                   pclk,
    input  logic                   rst_n,
    input  logic [`TLP_KIND_W-1:0] kind,
    input  logic [`TLP_DW_W-1:0]   dw0_base,
    input  logic                   four_dw,
    input  logic [`TLP_ID_W-1:0]   requester_id,
    input  logic [`TLP_TAG_W-1:0]  tag_hdr,
    input  logic                   tag_error,
    input  logic [3:0]             first_be,
    input  logic [3:0]             last_be,
    input  logic [`TLP_ID_W-1:0]   completer_id,
    input  logic [2:0]             cpl_status,
    input  logic                   bcm,
    input  logic [11:0]            byte_count,
    input  logic [6:0]             lower_addr,
    input  logic [`TLP_DW_W-1:0]   addr_lo,
    input  logic [`TLP_DW_W-1:0]   addr_hi,
    input  logic [7:0]             bus,
    input  logic [4:0]             dev,
    input  logic [2:0]             fn,
    input  logic [5:0]             reg_num,
    input  logic [3:0]             ext_reg,
    output logic [`TLP_DW_W-1:0]   hdr_dw0,
    output tlp_dw1_u               hdr_dw1,
    output logic [`TLP_DW_W-1:0]   hdr_dw2,
    output logic [`TLP_DW_W-1:0]   hdr_dw3,
    output logic                   four_dw_q,
    output logic                   tag_error_q
);

    logic [`TLP_DW_W-1:0] dw0_nxt;
    tlp_dw1_u             dw1_nxt;
    logic [`TLP_DW_W-1:0] dw2_nxt;
    logic [`TLP_DW_W-1:0] dw3_nxt;
    logic [`TLP_DW_W-1:0] addr_dw;       // DW-aligned low address

    assign addr_dw = {addr_lo[31:2], 2'b00};

    always_comb begin
        dw0_nxt     = dw0_base;
        dw0_nxt[23] = tag_hdr[9];        // T9
        dw0_nxt[19] = tag_hdr[8];        // T8
    end

    always_comb begin
        if (kind == `TLP_KIND_CPL) begin
            dw1_nxt.cpl.completer_id = completer_id;
            dw1_nxt.cpl.status       = cpl_status;
            dw1_nxt.cpl.bcm          = bcm;
            dw1_nxt.cpl.byte_count   = byte_count;
        end else begin
            dw1_nxt.req.requester_id = requester_id;
            dw1_nxt.req.tag          = tag_hdr[7:0];
            case (kind)
                `TLP_KIND_CFG0: begin
                    dw1_nxt.req.first_be = 4'b1111;  // Whole config DW
                    dw1_nxt.req.last_be  = 4'b0000;
                end
                `TLP_KIND_IO: begin
                    dw1_nxt.req.first_be = first_be;
                    dw1_nxt.req.last_be  = 4'b0000;  // Single DW
                end
                default: begin
                    dw1_nxt.req.first_be = first_be;
                    dw1_nxt.req.last_be  = last_be;
                end
            endcase
        end
    end

    always_comb begin
        case (kind)
            `TLP_KIND_CPL:  dw2_nxt = {requester_id, tag_hdr[7:0], 1'b0, lower_addr};
            `TLP_KIND_CFG0: dw2_nxt = {bus, dev, fn, 4'b0000, ext_reg, reg_num, 2'b00};
            default:        dw2_nxt = four_dw ? addr_hi : addr_dw;  // Upper half first
        endcase
        dw3_nxt = four_dw ? addr_dw : '0;
    end

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_dw0     <= '0;
            hdr_dw1     <= '0;
            hdr_dw2     <= '0;
            hdr_dw3     <= '0;
            four_dw_q   <= 1'b0;
            tag_error_q <= 1'b0;
        end else begin
            hdr_dw0     <= dw0_nxt;
            hdr_dw1     <= dw1_nxt;
            hdr_dw2     <= dw2_nxt;
            hdr_dw3     <= dw3_nxt;
            four_dw_q   <= four_dw;
            tag_error_q <= tag_error;
        end
    end

    // A rejected tag never reaches the T9/T8 slots
    a_tag_trim: assert property (@(posedge pclk) disable iff (!rst_n)
        tag_error |-> (tag_hdr[9:8] == 2'b00));

endmodule

/* logic/tlp_pkg.sv */
`include "tlp_macros.svh"

package tlp_pkg;

    // DW1 of a request header
    typedef struct packed {
        logic [`TLP_ID_W-1:0] requester_id;  // Bus, dev/fn or ARI fn
        logic [7:0]           tag;           // Tag low byte
        logic [3:0]           last_be;
        logic [3:0]           first_be;
    } tlp_req_dw1_t;

    // DW1 of a completion header
    typedef struct packed {
        logic [`TLP_ID_W-1:0] completer_id;
        logic [2:0]           status;        // Passed through, not decoded
        logic                 bcm;           // Byte count modified
        logic [11:0]          byte_count;
    } tlp_cpl_dw1_t;

    // Same word, two views
    typedef union packed {
        tlp_req_dw1_t req;
        tlp_cpl_dw1_t cpl;
    } tlp_dw1_u;

endpackage

/* logic/tlp_req_id_tag.sv */
`timescale 1ns/1ps
`include "tlp_macros.svh"

module tlp_req_id_tag
    import tlp_pkg::*;
#(
    parameter int support_10bit_tag = `TLP_SUPPORT_10BIT_TAG_DEF  // 1: tag bits 9:8 pass
)
(
    input  logic [7:0]            bus,
    input  logic [4:0]            dev,
    input  logic [2:0]            fn,
    input  logic [7:0]            ari_fn,
    input  logic                  ari_enabled,
    input  logic [`TLP_TAG_W-1:0] tag,
    output logic [`TLP_ID_W-1:0]  requester_id,
    output logic [`TLP_TAG_W-1:0] tag_hdr,
    output logic                  tag_error
);

    logic [7:0] fn_field;                // Low byte of the routing ID

    // ARI folds device into an 8-bit function number
    assign fn_field     = ari_enabled ? ari_fn : {dev, fn};
    assign requester_id = {bus, fn_field};

    generate
        if (support_10bit_tag != 0) begin : g_tag10
            assign tag_hdr   = tag;      // Full 10-bit tag
            assign tag_error = 1'b0;
        end else begin : g_tag8
            assign tag_hdr   = {2'b00, tag[7:0]};  // Upper bits trimmed
            assign tag_error = (tag[9:8] != 2'b00);
        end
    endgenerate

endmodule

/* tlp_gen.f */
+incdir+include
logic/tlp_pkg.sv
logic/tlp_apb_regs.sv
logic/tlp_req_id_tag.sv
logic/tlp_dw0_encode.sv
logic/tlp_hdr_assemble.sv
logic/tlp_gen_top.sv
verif/tb_clk_gen.sv
verif/tlp_gen_tb.sv

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int half_period  = 4,      // 8 ns clock
    parameter int reset_cycles = 3
) (
    output logic pclk,
    output logic rst_n
);

    initial begin
        pclk = 1'b0;
        forever #(half_period) pclk = ~pclk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge pclk);
        #1;
        rst_n = 1'b1;                    // Released off the clock edge
    end

endmodule

/* verif/tlp_gen_tb.sv */
`timescale 1ns/1ps
`include "tlp_macros.svh"

module tlp_gen_tb;

    localparam int tag10        = 0;     // DUT built for 8-bit tags
    localparam int num_trials   = 200;
    localparam int trial_cycles = 30;    // 12 transfers of 2 cycles plus idle
    localparam int timeout_ns   = num_trials * trial_cycles * 8 + 2000;

    typedef logic [4:0][31:0] hdr_words_t;  // DW0..DW3, then STAT

    logic        pclk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    integer      seed = 10;
    int          err_count = 0;
    int          chk_count = 0;

    tb_clk_gen u_clk (.pclk, .rst_n);

    tlp_gen_top #(.support_10bit_tag(tag10)) i_dut (
        .pclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    function automatic void check_word(input string name, input logic [31:0] exp,
                                       input logic [31:0] act);
        chk_count++;
        assert (act === exp) else begin
            $display("FAIL %s expected %08h got %08h at %0t", name, exp, act, $time);
            err_count++;
        end
    endfunction

    // Header words built from the field rules of each kind
    function automatic hdr_words_t expected_header(input logic [31:0] ctrl, len, id, tagw,
                                                   cpl, alo, ahi);
        hdr_words_t  w;
        logic [2:0]  kind;
        logic [2:0]  tc;
        logic [2:0]  attr;
        logic [4:0]  typ;
        logic        four;
        logic        td;
        logic        ep;
        logic [9:0]  length;
        logic [9:0]  tag;
        logic [15:0] rid;
        logic [31:0] a_dw;
        kind   = ctrl[2:0];
        four   = (kind == `TLP_KIND_MEM) && ctrl[4];  // 4DW only for 64-bit memory
        tc     = ctrl[9:7];
        attr   = ctrl[12:10];
        td     = ctrl[5];
        ep     = ctrl[6];
        length = len[9:0];
        typ    = `TLP_TYPE_MEM;
        if (kind == `TLP_KIND_IO || kind == `TLP_KIND_CFG0) begin
            typ    = (kind == `TLP_KIND_IO) ? `TLP_TYPE_IO : `TLP_TYPE_CFG0;
            tc     = 3'd0;               // TC0, no attributes, one DW
            attr   = 3'd0;
            length = 10'd1;
        end
        if (kind == `TLP_KIND_CFG0 || kind == `TLP_KIND_CPL) begin
            td = 1'b0;
            ep = 1'b0;
        end
        if (kind == `TLP_KIND_CPL)
            typ = `TLP_TYPE_CPL;
        tag  = (tag10 != 0) ? tagw[9:0] : {2'b00, tagw[7:0]};
        rid  = ctrl[13] ? {id[7:0], id[23:16]} : {id[7:0], id[12:8], id[15:13]};
        a_dw = {alo[31:2], 2'b00};
        w[0] = {1'b0, ctrl[3], four, typ, tag[9], tc, tag[8], attr[2], 2'b00,
                td, ep, attr[1:0], 2'b00, length};
        case (kind)
            `TLP_KIND_CPL: begin
                w[1] = {cpl[15:0], tagw[12:10], tagw[13], tagw[25:14]};
                w[2] = {rid, tag[7:0], 1'b0, cpl[22:16]};
            end
            `TLP_KIND_CFG0: begin
                w[1] = {rid, tag[7:0], 4'b0000, 4'b1111};
                w[2] = {id[7:0], id[12:8], id[15:13], 4'b0000, ctrl[17:14], cpl[28:23], 2'b00};
            end
            `TLP_KIND_IO: begin
                w[1] = {rid, tag[7:0], 4'b0000, len[13:10]};
                w[2] = a_dw;
            end
            default: begin
                w[1] = {rid, tag[7:0], len[17:14], len[13:10]};
                w[2] = four ? ahi : a_dw;  // High half leads in a 4DW header
            end
        endcase
        w[3] = four ? a_dw : 32'd0;
        w[4] = {30'd0, four, (tag10 == 0) && (tagw[9:8] != 2'b00)};
        return w;
    endfunction

    // Ends in the access phase so a next transfer can follow back to back
    task automatic transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge pclk);
        #1;
        psel    = 1'b1;                  // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge pclk);
        #1;
        penable = 1'b1;                  // Access phase
        @(negedge pclk);                 // Mid-cycle, outputs settled
        rdata = prdata;
        err   = pslverr;
        chk_count++;
        assert (pready === 1'b1) else begin
            $display("pready was low in the access phase at address %02h", addr);
            err_count++;
        end
    endtask

    task automatic go_idle();
        @(posedge pclk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        transfer(1'b1, addr, data, rdata, err);
        check_word("pslverr", {31'd0, exp_err}, {31'd0, err});
    endtask

    task automatic read_check(input logic [7:0] addr, input string name,
                              input logic [31:0] exp, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        transfer(1'b0, addr, 32'd0, rdata, err);
        check_word("pslverr", {31'd0, exp_err}, {31'd0, err});
        check_word(name, exp, rdata);
    endtask

    task automatic run_trial();
        logic [31:0] ctrl, len, id, tagw, cpl, alo, ahi, pick;
        hdr_words_t  exp;
        ctrl      = $random(seed);
        len       = $random(seed);
        id        = $random(seed);
        tagw      = $random(seed);       // Tag bits 9:8 often nonzero
        cpl       = $random(seed);
        alo       = $random(seed);
        ahi       = $random(seed);
        pick      = $random(seed);
        ctrl[2:0] = {1'b0, pick[1:0]};   // MEM, IO, CFG0 or CPL
        exp       = expected_header(ctrl, len, id, tagw, cpl, alo, ahi);
        write_reg(`TLP_ADDR_ALO, alo, 1'b0);
        write_reg(`TLP_ADDR_AHI, ahi, 1'b0);
        write_reg(`TLP_ADDR_ID, id, 1'b0);
        write_reg(`TLP_ADDR_TAG, tagw, 1'b0);
        write_reg(`TLP_ADDR_CPL, cpl, 1'b0);
        write_reg(`TLP_ADDR_LEN, len, 1'b0);
        write_reg(`TLP_ADDR_CTRL, ctrl, 1'b0);
        read_check(`TLP_ADDR_DW0, "hdr_dw0", exp[0], 1'b0);  // Right behind the CTRL write
        read_check(`TLP_ADDR_DW1, "hdr_dw1", exp[1], 1'b0);
        read_check(`TLP_ADDR_DW2, "hdr_dw2", exp[2], 1'b0);
        read_check(`TLP_ADDR_DW3, "hdr_dw3", exp[3], 1'b0);
        read_check(`TLP_ADDR_STAT, "stat", exp[4], 1'b0);
        go_idle();
    endtask

    initial begin : watchdog
        #(timeout_ns);
        $display("Timeout: the run did not finish within %0d ns", timeout_ns);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : stimulus
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h00;
        pwdata  = 32'd0;
        wait (rst_n === 1'b1);
        read_check(`TLP_ADDR_DW0, "hdr_dw0", 32'd0, 1'b0);
        read_check(`TLP_ADDR_DW1, "hdr_dw1", 32'd0, 1'b0);
        read_check(`TLP_ADDR_DW2, "hdr_dw2", 32'd0, 1'b0);
        read_check(`TLP_ADDR_DW3, "hdr_dw3", 32'd0, 1'b0);
        read_check(`TLP_ADDR_STAT, "stat", 32'd0, 1'b0);
        read_check(8'h40, "prdata", 32'd0, 1'b1);  // Unmapped
        write_reg(`TLP_ADDR_DW0, 32'hFFFF_FFFF, 1'b1);  // Read-only, dropped
        read_check(`TLP_ADDR_DW0, "hdr_dw0", 32'd0, 1'b0);
        go_idle();
        repeat (num_trials) run_trial();
        $display("Checks: %0d, errors: %0d", chk_count, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
